// File: build.f
+incdir+include
logic/imuldiv_pkg.sv
logic/imuldiv_mul_dpath.sv
logic/imuldiv_mul_ctrl.sv
logic/imuldiv_div_iterative.sv
logic/imuldiv_dispatch.sv
logic/imuldiv.sv
bench/imuldiv_assert.sv
bench/imuldiv_tb.sv

// File: Makefile
# Verilator build and run of the multiply/divide testbench
TOP := imuldiv_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o $(TOP)

# pass only when the output holds the pass line
run: compile
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// File: bench/imuldiv_tb.sv
// self-checking testbench for the iterative multiply/divide unit
// one request in flight while resp_rdy stalls at random
// needs Verilator with --timing
`timescale 1ns/1ps
`default_nettype none
`include "imuldiv_macros.svh"

module imuldiv_tb;

  import imuldiv_pkg::*;

  localparam int n_rand     = 150;
  localparam int latency    = 33;
  localparam int wait_limit = 2000;
  localparam logic [31:0] corners [6] = '{
    32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
    32'h8000_0000, 32'h7fff_ffff, 32'h0000_0007
  };

  logic          clk;
  logic          reset;
  imuldiv_req_t  req_msg;
  logic          req_val;
  logic          req_rdy;
  imuldiv_resp_t resp_msg;
  logic          resp_val;
  logic          resp_rdy;

  // expected results in request order
  logic [`IMULDIV_RES_W-1:0] exp_q[$];
  int unsigned cycle_cnt;
  int unsigned accept_cycle;
  logic        lat_open;
  int          done_cnt;
  int          issued;
  int          errors;
  int          checks;
  logic [31:0] stim_state;
  logic [31:0] rdy_state;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  imuldiv u_dut (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    lcg_next = s * 32'd1664525 + 32'd1013904223;
  endfunction

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic logic [`IMULDIV_RES_W-1:0] ref_result(input imuldiv_req_t r);
    logic signed [63:0] pa;
    logic signed [63:0] pb;
    logic [31:0]        q;
    logic [31:0]        rm;
    pa = {{32{r.a[31]}}, r.a};
    pb = {{32{r.b[31]}}, r.b};
    q  = '1;
    rm = r.a;
    if (r.fn == FN_MUL) begin
      return pa * pb;
    end
    // zero divisor keeps q all ones and rm the dividend
    if (r.b != '0) begin
      if (r.fn != FN_DIV) begin
        q  = r.a / r.b;
        rm = r.a % r.b;
      end else if (r.a == 32'h8000_0000 && r.b == '1) begin
        // overflow wraps back to the dividend
        q  = r.a;
        rm = '0;
      end else begin
        // truncating division where the remainder takes the dividend sign
        q  = $signed(r.a) / $signed(r.b);
        rm = $signed(r.a) % $signed(r.b);
      end
    end
    return {rm, q};
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  // ----------------------------------------
  // compare process
  // ----------------------------------------
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (!reset) begin
      // first sighting of resp_val fixes the latency
      if (resp_val && lat_open) begin
        compare_value("resp_val latency", 64'(cycle_cnt - accept_cycle), 64'(latency));
        lat_open = 1'b0;
      end
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("a response transferred with no request outstanding");
        end else begin
          compare_value("resp_msg.result", resp_msg.result, exp_q.pop_front());
        end
        done_cnt <= done_cnt + 1;
      end
      if (req_val && req_rdy) begin
        // a second accept before the response would show up here
        compare_value("ops outstanding at accept", 64'(exp_q.size()), 64'd0);
        exp_q.push_back(ref_result(req_msg));
        accept_cycle = cycle_cnt;
        lat_open     = 1'b1;
      end
    end
  end

  // random back-pressure that holds resp_rdy low about a quarter of the time
  always @(posedge clk) begin
    rdy_state = lcg_next(rdy_state);
    if (reset) begin
      resp_rdy <= 1'b0;
    end else begin
      resp_rdy <= (rdy_state[22:21] != 2'b00);
    end
  end

  // drive one request and hold it until accepted
  // then maybe idle a few cycles
  task automatic send_request(input imuldiv_fn_e fn, input logic [31:0] a,
                              input logic [31:0] b, output logic ok);
    int t;
    ok          = 1'b0;
    req_msg.fn <= fn;
    req_msg.a  <= a;
    req_msg.b  <= b;
    req_val    <= 1'b1;
    issued++;
    for (t = 0; t < wait_limit && !ok; t++) begin
      @(posedge clk);
      ok = req_val && req_rdy;
    end
    if (!ok) begin
      errors++;
      $display("timed out waiting for the DUT to accept request %0d", issued);
    end else begin
      stim_state = lcg_next(stim_state);
      if (stim_state[31:29] == 3'd0) begin
        req_val <= 1'b0;
        repeat (stim_state[27:26] + 1) @(posedge clk);
      end
    end
  endtask

  initial begin : drive
    logic        ok;
    int          i;
    int          j;
    int          f;
    int          t;
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] ctl;
    reset      <= 1'b1;
    req_val    <= 1'b0;
    req_msg    <= '0;
    resp_rdy   <= 1'b0;
    cycle_cnt  <= 0;
    lat_open   = 1'b0;
    done_cnt   <= 0;
    issued     = 0;
    errors     = 0;
    checks     = 0;
    stim_state = 32'd56;
    rdy_state  = 32'd56;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    compare_value("resp_val after reset", 64'(resp_val), 64'd0);
    compare_value("req_rdy after reset", 64'(req_rdy), 64'd1);

    // ----------------------------------------
    // directed corners with every pair for every code
    // ----------------------------------------
    ok = 1'b1;
    for (f = 0; f < 3 && ok; f++) begin
      for (i = 0; i < 6 && ok; i++) begin
        for (j = 0; j < 6 && ok; j++) begin
          send_request(imuldiv_fn_e'(f), corners[i], corners[j], ok);
        end
      end
    end

    // random operands
    for (i = 0; i < n_rand && ok; i++) begin
      stim_state = lcg_next(stim_state);
      ra         = stim_state;
      stim_state = lcg_next(stim_state);
      rb         = stim_state;
      stim_state = lcg_next(stim_state);
      ctl        = stim_state;
      // narrower divisors give larger quotients
      if (ctl[27:26] != 2'b00) begin
        rb = $signed(rb) >>> ctl[24:20];
      end
      if (ctl[19:16] == 4'd0) begin
        rb = '0;
      end
      send_request(imuldiv_fn_e'((ctl[31:30] == 2'd3) ? 2'd0 : ctl[31:30]), ra, rb, ok);
    end
    req_val <= 1'b0;

    // drain the last response
    if (ok) begin
      for (t = 0; t < wait_limit && done_cnt != issued; t++) begin
        @(posedge clk);
      end
      if (done_cnt != issued) begin
        errors++;
        $display("timed out waiting for the last response");
      end
    end

    $display("ops=%0d checks=%0d errors=%0d assertion_failures=%0d",
             issued, checks, errors, u_dut.u_assert.fail_cnt);
    if (errors == 0 && u_dut.u_assert.fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/imuldiv_assert.sv
// handshake properties of the multiply/divide top level
// bound into every imuldiv instance, needs assertions enabled
`timescale 1ns/1ps
`default_nettype none

module imuldiv_assert (
  input logic                       clk,
  input logic                       reset,
  input logic                       req_rdy,
  input imuldiv_pkg::imuldiv_resp_t resp_msg,
  input logic                       resp_val,
  input logic                       resp_rdy
);

  int fail_cnt;

  initial fail_cnt = 0;

  // a stalled response holds its payload
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(resp_msg))
  else begin
    $error("resp_msg changed while the response was stalled");
    fail_cnt++;
  end

  // one operation in flight
  assert property (@(posedge clk) disable iff (reset) resp_val |-> !req_rdy)
  else begin
    $error("req_rdy high while resp_val is high");
    fail_cnt++;
  end

  assert property (@(posedge clk) reset |=> !resp_val)
  else begin
    $error("resp_val high in the cycle after reset");
    fail_cnt++;
  end

endmodule

bind imuldiv imuldiv_assert u_assert (
  .clk      (clk),
  .reset    (reset),
  .req_rdy  (req_rdy),
  .resp_msg (resp_msg),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy)
);

`default_nettype wire

// File: logic/imuldiv.sv
// iterative multiply/divide unit, one operation in flight
// 33 cycles from request handshake to resp_val for every function
`timescale 1ns/1ps
`default_nettype none
`include "imuldiv_macros.svh"

module imuldiv (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_pkg::imuldiv_req_t   req_msg,
  input  logic                        req_val,
  output logic                        req_rdy,
  output imuldiv_pkg::imuldiv_resp_t  resp_msg,
  output logic                        resp_val,
  input  logic                        resp_rdy
);

  import imuldiv_pkg::*;

  // ----------------------------------------
  // unit channels
  // ----------------------------------------
  logic                      mul_req_val;
  logic                      mul_req_rdy;
  logic                      mul_resp_val;
  logic                      mul_resp_rdy;
  logic [`IMULDIV_RES_W-1:0] mul_result;
  logic                      div_req_val;
  logic                      div_req_rdy;
  imuldiv_resp_t             div_resp;
  logic                      div_resp_val;
  logic                      div_resp_rdy;

  // multiplier control to datapath
  logic a_en;
  logic a_sel;
  logic b_en;
  logic b_sel;
  logic result_en;
  logic add_sel;
  logic cntr_sel;
  logic sign_en;
  logic sign_fix;
  logic counter_is_zero;
  logic b_lsb;
  logic sign;

  imuldiv_dispatch u_dispatch (
    .clk          (clk),
    .reset        (reset),
    .req_msg      (req_msg),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .resp_msg     (resp_msg),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .mul_result   (mul_result),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .div_resp     (div_resp),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy)
  );

  imuldiv_mul_ctrl u_mul_ctrl (
    .clk             (clk),
    .reset           (reset),
    .req_val         (mul_req_val),
    .req_rdy         (mul_req_rdy),
    .resp_val        (mul_resp_val),
    .resp_rdy        (mul_resp_rdy),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb),
    .sign            (sign),
    .a_en            (a_en),
    .a_sel           (a_sel),
    .b_en            (b_en),
    .b_sel           (b_sel),
    .result_en       (result_en),
    .add_sel         (add_sel),
    .cntr_sel        (cntr_sel),
    .sign_en         (sign_en),
    .sign_fix        (sign_fix)
  );

  // operands come straight from the request port
  imuldiv_mul_dpath u_mul_dpath (
    .clk             (clk),
    .reset           (reset),
    .a               (req_msg.a),
    .b               (req_msg.b),
    .a_en            (a_en),
    .a_sel           (a_sel),
    .b_en            (b_en),
    .b_sel           (b_sel),
    .result_en       (result_en),
    .add_sel         (add_sel),
    .cntr_sel        (cntr_sel),
    .sign_en         (sign_en),
    .sign_fix        (sign_fix),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb),
    .sign            (sign),
    .result          (mul_result)
  );

  imuldiv_div_iterative u_div (
    .clk      (clk),
    .reset    (reset),
    .req      (req_msg),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp     (div_resp),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

endmodule

`default_nettype wire

// File: logic/imuldiv_dispatch.sv
// steers one request at a time to the multiplier or the divider
// request payload goes to the units directly, only val/rdy pass through here
`timescale 1ns/1ps
`default_nettype none
`include "imuldiv_macros.svh"

module imuldiv_dispatch (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_pkg::imuldiv_req_t   req_msg,
  input  logic                        req_val,
  output logic                        req_rdy,
  output imuldiv_pkg::imuldiv_resp_t  resp_msg,
  output logic                        resp_val,
  input  logic                        resp_rdy,
  output logic                        mul_req_val,
  input  logic                        mul_req_rdy,
  input  logic                        mul_resp_val,
  output logic                        mul_resp_rdy,
  input  logic [`IMULDIV_RES_W-1:0]   mul_result,
  output logic                        div_req_val,
  input  logic                        div_req_rdy,
  input  imuldiv_pkg::imuldiv_resp_t  div_resp,
  input  logic                        div_resp_val,
  output logic                        div_resp_rdy
);

  import imuldiv_pkg::*;

  logic busy;
  // owner of the outstanding operation, set means divider
  logic owner_div;
  logic is_mul;
  logic unit_rdy;

  assign is_mul   = (req_msg.fn == FN_MUL);
  assign unit_rdy = is_mul ? mul_req_rdy : div_req_rdy;

  // ----------------------------------------
  // request side
  // ----------------------------------------
  assign req_rdy     = !busy && unit_rdy;
  assign mul_req_val = req_val && !busy && is_mul;
  assign div_req_val = req_val && !busy && !is_mul;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      owner_div <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy      <= 1'b1;
      owner_div <= !is_mul;
    end else if (resp_val && resp_rdy) begin
      busy <= 1'b0;
    end
  end

  // ----------------------------------------
  // response side, owner only
  // ----------------------------------------
  always_comb begin
    if (owner_div) begin
      resp_msg = div_resp;
      resp_val = busy && div_resp_val;
    end else begin
      resp_msg.result = mul_result;
      resp_val        = busy && mul_resp_val;
    end
  end

  assign mul_resp_rdy = busy && !owner_div && resp_rdy;
  assign div_resp_rdy = busy && owner_div && resp_rdy;

endmodule

`default_nettype wire

// File: logic/imuldiv_div_iterative.sv
// restoring divider, one quotient bit per cycle
// FN_DIV is signed, any other code divides unsigned
`timescale 1ns/1ps
`default_nettype none
`include "imuldiv_macros.svh"

module imuldiv_div_iterative (
  input  logic                         clk,
  input  logic                         reset,
  input  imuldiv_pkg::imuldiv_req_t    req,
  input  logic                         req_val,
  output logic                         req_rdy,
  output imuldiv_pkg::imuldiv_resp_t   resp,
  output logic                         resp_val,
  input  logic                         resp_rdy
);

  import imuldiv_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_e;

  state_e                    state;
  logic [`IMULDIV_CNT_W-1:0] cntr;

  logic [`IMULDIV_XLEN-1:0]  rem_reg;
  logic [`IMULDIV_XLEN-1:0]  quo_reg;
  logic [`IMULDIV_XLEN-1:0]  dvsr_reg;
  logic                      q_neg;
  logic                      r_neg;
  logic                      dvsr_zero;

  logic                      signed_op;
  logic [`IMULDIV_XLEN-1:0]  a_mag;
  logic [`IMULDIV_XLEN-1:0]  b_mag;
  logic [`IMULDIV_XLEN:0]    rem_shift;
  logic [`IMULDIV_XLEN+1:0]  diff;
  logic                      fits;
  logic [`IMULDIV_XLEN-1:0]  rem_out;
  logic [`IMULDIV_XLEN-1:0]  quo_out;

  // ----------------------------------------
  // operand preparation
  // ----------------------------------------
  assign signed_op = (req.fn == FN_DIV);
  assign a_mag = (signed_op && req.a[`IMULDIV_XLEN-1]) ? (~req.a + 1'b1) : req.a;
  assign b_mag = (signed_op && req.b[`IMULDIV_XLEN-1]) ? (~req.b + 1'b1) : req.b;

  // ----------------------------------------
  // one restoring step
  // ----------------------------------------
  // next dividend bit enters the partial remainder
  assign rem_shift = {rem_reg, quo_reg[`IMULDIV_XLEN-1]};
  // extra top bit is the borrow
  assign diff = {1'b0, rem_shift} - {2'b00, dvsr_reg};
  assign fits = ~diff[`IMULDIV_XLEN+1];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      cntr  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_val) begin
            state <= CALC;
            cntr  <= '1;
          end
        end
        CALC: begin
          cntr <= cntr - 1'b1;
          if (cntr == '0) begin
            state <= DONE;
          end
        end
        DONE: begin
          if (resp_rdy) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && req_val) begin
      rem_reg   <= '0;
      quo_reg   <= a_mag;
      dvsr_reg  <= b_mag;
      q_neg     <= signed_op && (req.a[`IMULDIV_XLEN-1] ^ req.b[`IMULDIV_XLEN-1]);
      r_neg     <= signed_op && req.a[`IMULDIV_XLEN-1];
      dvsr_zero <= (req.b == '0);
    end else if (state == CALC) begin
      // remainder stays below the divisor, so 32 bits hold it
      rem_reg <= fits ? diff[`IMULDIV_XLEN-1:0] : rem_shift[`IMULDIV_XLEN-1:0];
      quo_reg <= {quo_reg[`IMULDIV_XLEN-2:0], fits};
    end
  end

  // ----------------------------------------
  // sign correction and response
  // ----------------------------------------
  // a zero divisor leaves the all-ones quotient alone
  // remainder sign follows the dividend
  assign quo_out = (q_neg && !dvsr_zero) ? (~quo_reg + 1'b1) : quo_reg;
  assign rem_out = r_neg ? (~rem_reg + 1'b1) : rem_reg;

  assign req_rdy     = (state == IDLE);
  assign resp_val    = (state == DONE);
  assign resp.result = {rem_out, quo_out};

endmodule

`default_nettype wire

// File: logic/imuldiv_mul_ctrl.sv
// multiplier control FSM, one operation at a time
// result is valid only while resp_val is high
`timescale 1ns/1ps
`default_nettype none

module imuldiv_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  input  logic counter_is_zero,
  input  logic b_lsb,
  input  logic sign,
  output logic a_en,
  output logic a_sel,
  output logic b_en,
  output logic b_sel,
  output logic result_en,
  output logic add_sel,
  output logic cntr_sel,
  output logic sign_en,
  output logic sign_fix
);

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_e;

  state_e state;
  state_e state_next;

  // ----------------------------------------
  // state register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:    if (req_val) state_next = CALC;
      // last step runs with the counter at zero
      CALC:    if (counter_is_zero) state_next = DONE;
      DONE:    if (resp_rdy) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  // ----------------------------------------
  // per-state datapath controls
  // ----------------------------------------
  always_comb begin
    req_rdy   = (state == IDLE);
    resp_val  = (state == DONE);
    a_en      = 1'b0;
    a_sel     = 1'b0;
    b_en      = 1'b0;
    b_sel     = 1'b0;
    result_en = 1'b0;
    add_sel   = 1'b0;
    cntr_sel  = 1'b0;
    sign_en   = 1'b0;
    sign_fix  = 1'b0;
    case (state)
      IDLE: begin
        // load magnitudes and capture the sign on accept
        a_en      = req_val;
        b_en      = req_val;
        result_en = req_val;
        sign_en   = req_val;
      end
      CALC: begin
        a_en      = 1'b1;
        a_sel     = 1'b1;
        b_en      = 1'b1;
        b_sel     = 1'b1;
        result_en = 1'b1;
        add_sel   = b_lsb;
        cntr_sel  = 1'b1;
      end
      DONE: begin
        // everything frozen, only the sign fix is applied
        sign_fix = sign;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/imuldiv_mul_dpath.sv
// signed multiplier datapath, one bit of b per cycle
// operands must stay stable in the cycle the control loads them
`timescale 1ns/1ps
`default_nettype none
`include "imuldiv_macros.svh"

module imuldiv_mul_dpath (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`IMULDIV_XLEN-1:0]  a,
  input  logic [`IMULDIV_XLEN-1:0]  b,
  input  logic                      a_en,
  input  logic                      a_sel,
  input  logic                      b_en,
  input  logic                      b_sel,
  input  logic                      result_en,
  input  logic                      add_sel,
  input  logic                      cntr_sel,
  input  logic                      sign_en,
  input  logic                      sign_fix,
  output logic                      counter_is_zero,
  output logic                      b_lsb,
  output logic                      sign,
  output logic [`IMULDIV_RES_W-1:0] result
);

  logic [`IMULDIV_RES_W-1:0] a_reg;
  logic [`IMULDIV_XLEN-1:0]  b_reg;
  logic [`IMULDIV_RES_W-1:0] acc_reg;
  logic [`IMULDIV_CNT_W-1:0] cntr_reg;
  logic                      sign_reg;

  logic [`IMULDIV_XLEN-1:0]  a_mag;
  logic [`IMULDIV_XLEN-1:0]  b_mag;
  logic [`IMULDIV_RES_W-1:0] a_next;
  logic [`IMULDIV_XLEN-1:0]  b_next;
  logic [`IMULDIV_RES_W-1:0] acc_next;
  logic [`IMULDIV_CNT_W-1:0] cntr_next;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------
  assign a_mag = a[`IMULDIV_XLEN-1] ? (~a + 1'b1) : a;
  assign b_mag = b[`IMULDIV_XLEN-1] ? (~b + 1'b1) : b;

  // ----------------------------------------
  // next-value muxes
  // ----------------------------------------
  always_comb begin
    // a widens to 64 bits so it can shift left for all 32 steps
    a_next = a_sel ? (a_reg << 1) : {{(`IMULDIV_RES_W-`IMULDIV_XLEN){1'b0}}, a_mag};
    b_next = b_sel ? (b_reg >> 1) : b_mag;
    // load phase restarts the count at all ones
    cntr_next = cntr_sel ? (cntr_reg - 1'b1) : '1;
    // load phase clears the accumulator, calc adds a on a set b lsb
    if (!a_sel) begin
      acc_next = '0;
    end else if (add_sel) begin
      acc_next = acc_reg + a_reg;
    end else begin
      acc_next = acc_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
    if (b_en) begin
      b_reg <= b_next;
    end
    if (result_en) begin
      acc_reg <= acc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cntr_reg <= '0;
      sign_reg <= 1'b0;
    end else begin
      cntr_reg <= cntr_next;
      // product is negative when exactly one operand is
      if (sign_en) begin
        sign_reg <= a[`IMULDIV_XLEN-1] ^ b[`IMULDIV_XLEN-1];
      end
    end
  end

  assign counter_is_zero = (cntr_reg == '0);
  assign b_lsb           = b_reg[0];
  assign sign            = sign_reg;
  // sign restore on the way out
  assign result          = sign_fix ? (~acc_reg + 1'b1) : acc_reg;

endmodule

`default_nettype wire

// File: logic/imuldiv_pkg.sv
// request and response types of the multiply/divide unit
// fn codes other than the three below are not defined
`default_nettype none
`include "imuldiv_macros.svh"

package imuldiv_pkg;

  // function codes carried in every request
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } imuldiv_fn_e;

  // request message, 66 bits
  typedef struct packed {
    imuldiv_fn_e              fn;
    logic [`IMULDIV_XLEN-1:0] a;
    logic [`IMULDIV_XLEN-1:0] b;
  } imuldiv_req_t;

  // response message
  // divides pack the remainder high and the quotient low
  typedef struct packed {
    logic [`IMULDIV_RES_W-1:0] result;
  } imuldiv_resp_t;

endpackage

`default_nettype wire

// File: include/imuldiv_macros.svh
// widths shared by the multiply/divide unit, fixed for a 32-bit core
// the counter width must hold XLEN-1
`ifndef IMULDIV_MACROS_SVH
`define IMULDIV_MACROS_SVH

// operand width
`define IMULDIV_XLEN 32

// full product width, also remainder/quotient pair
`define IMULDIV_RES_W 64

// iteration counter width, counts XLEN-1 down to 0
`define IMULDIV_CNT_W 5

`endif
